// ==== common/regPkg.sv ====
/*
 * APB register address type and register map offsets
 */
`include "sw_defines.svh"

package regPkg;

    typedef logic [`SW_APB_ADDR_W-1:0] regAddrT;

    // scoring registers, read/write
    localparam regAddrT REG_MATCH = 8'h00;
    localparam regAddrT REG_MISMATCH = 8'h04;
    localparam regAddrT REG_GAP = 8'h08;

    // event counters, read only
    localparam regAddrT REG_TARGET_COUNT = 8'h0C;
    localparam regAddrT REG_SCORE_COUNT = 8'h10;

endpackage

// ==== common/swPkg.sv ====
/*
 * alignment data types shared by the cell array, the score tracker
 * and the top level
 */
`include "sw_defines.svh"

package swPkg;

    // one nucleotide code
    typedef logic [`SW_BASE_W-1:0] baseT;

    // signed DP table entry, wraps on overflow
    typedef logic signed [`SW_SCORE_W-1:0] scoreT;

    // index of a target base
    typedef logic [`SW_T_POS_W-1:0] tPosT;

    // packed query, base 0 sits in the low bits
    typedef logic [`SW_MAX_QUERY_LEN*`SW_BASE_W-1:0] queryT;

    // per-base enables, clear bits mask off unused cells
    typedef logic [`SW_MAX_QUERY_LEN-1:0] queryMaskT;

endpackage

// ==== common/sw_defines.svh ====
/*
 * aligner sizing macros, APB address width and reset scoring values
 */
`ifndef SW_DEFINES_SVH
`define SW_DEFINES_SVH

// number of systolic cells, one query base each
`define SW_MAX_QUERY_LEN 16

// widths
`define SW_BASE_W 2
// signed DP score
`define SW_SCORE_W 10
`define SW_T_POS_W 8
`define SW_Q_POS_W 4

// register block address width
`define SW_APB_ADDR_W 8

// scoring values loaded at reset
`define SW_MATCH_RST 2
`define SW_MISMATCH_RST -1
`define SW_GAP_RST -2

`endif

// ==== list.f ====
+incdir+common
+incdir+tb
common/swPkg.sv
common/regPkg.sv
systolicArray/swCell.sv
systolicArray/targetSequencer.sv
systolicArray/systolicArray.sv
src/scoreTracker.sv
src/alignConfigApb.sv
src/swAligner.sv
tb/tbSwAligner.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the aligner testbench with Verilator, run it, and grade the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f list.f --top-module tbSwAligner --Mdir obj_dir -o simAligner \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/simAligner > sim.log 2>&1

cat sim.log
grep -qx "sim passed" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

// ==== src/alignConfigApb.sv ====
/*
 * APB slave with the scoring registers and the target/score counters
 */
`timescale 1ns/1ps
`include "sw_defines.svh"

module alignConfigApb (
    input  logic            clk,
    input  logic            rst,
    input  regPkg::regAddrT paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [31:0]     pwdata,
    input  logic            targetStarted,
    input  logic            scoreAccepted,
    output logic [31:0]     prdata,
    output logic            pslverr,
    output swPkg::scoreT    match,
    output swPkg::scoreT    mismatch,
    output swPkg::scoreT    gap
);

    logic        access;
    logic        mapped;
    logic        readOnly;
    logic [31:0] targetCount;
    logic [31:0] scoreCount;

    // every transfer completes in its access phase
    assign access = psel & penable;

    ////////////////////////////////////////////////////////////
    // address decode and read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        mapped   = 1'b1;
        readOnly = 1'b0;
        prdata   = '0;
        case (paddr)
            regPkg::REG_MATCH:    prdata = 32'(match);
            regPkg::REG_MISMATCH: prdata = 32'(mismatch);
            regPkg::REG_GAP:      prdata = 32'(gap);
            regPkg::REG_TARGET_COUNT: begin
                prdata   = targetCount;
                readOnly = 1'b1;
            end
            regPkg::REG_SCORE_COUNT: begin
                prdata   = scoreCount;
                readOnly = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    assign pslverr = access & (!mapped | (pwrite & readOnly));

    // scores only change between targets
    always_ff @(posedge clk) begin
        if (rst) begin
            match    <= `SW_MATCH_RST;
            mismatch <= `SW_MISMATCH_RST;
            gap      <= `SW_GAP_RST;
        end else if (access && pwrite) begin
            case (paddr)
                regPkg::REG_MATCH:    match    <= pwdata[`SW_SCORE_W-1:0];
                regPkg::REG_MISMATCH: mismatch <= pwdata[`SW_SCORE_W-1:0];
                regPkg::REG_GAP:      gap      <= pwdata[`SW_SCORE_W-1:0];
                default: ;
            endcase
        end
    end

    // event counters
    always_ff @(posedge clk) begin
        if (rst) begin
            targetCount <= '0;
            scoreCount  <= '0;
        end else begin
            targetCount <= targetCount + 32'(targetStarted);
            scoreCount  <= scoreCount + 32'(scoreAccepted);
        end
    end

endmodule

// ==== src/scoreTracker.sv ====
/*
 * best bottom-row score and target index, one-entry result buffer
 */
`timescale 1ns/1ps
`include "sw_defines.svh"

module scoreTracker (
    input  logic         clk,
    input  logic         rst,
    input  logic         stepEn,
    input  logic         bottomStart,
    input  logic         bottomLast,
    input  swPkg::scoreT bottomH,
    input  logic         scoreReady,
    output swPkg::scoreT score,
    output swPkg::tPosT  scoreJ,
    output logic         scoreValid,
    output logic         scoreAccepted
);

    swPkg::scoreT bestH;
    swPkg::tPosT  bestJ;
    // position of the bottom H seen on this step
    swPkg::tPosT  posCnt;

    ////////////////////////////////////////////////////////////
    // running best
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (stepEn) begin
            if (bottomStart) begin
                // column 0 seeds the search
                bestH  <= bottomH;
                bestJ  <= '0;
                posCnt <= '0;
            end else begin
                posCnt <= posCnt + 1'b1;
                // strict compare, earliest position keeps a tie
                if (bottomH > bestH) begin
                    bestH <= bottomH;
                    bestJ <= posCnt;
                end
            end
        end
    end

    // result buffer
    always_ff @(posedge clk) begin
        if (bottomLast) begin
            score  <= bestH;
            scoreJ <= bestJ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scoreValid <= 1'b0;
        end else if (bottomLast) begin
            scoreValid <= 1'b1;
        end else if (scoreReady) begin
            scoreValid <= 1'b0;
        end
    end

    assign scoreAccepted = scoreValid & scoreReady;

    // a new result must not land on an unaccepted one
    trackNoOverflow: assert property (@(posedge clk) disable iff (rst)
        bottomLast |-> (!scoreValid || scoreReady));

endmodule

// ==== src/swAligner.sv ====
/*
 * aligner top level, array, tracker and register block
 */
`timescale 1ns/1ps

module swAligner (
    input  logic             clk,
    input  logic             rst,
    // APB
    input  regPkg::regAddrT  paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pslverr,
    // query
    input  swPkg::queryT     queryIn,
    input  swPkg::queryMaskT queryEn,
    output swPkg::queryMaskT queryReady,
    // target stream
    input  swPkg::baseT      targetIn,
    input  logic             targetInStart,
    input  logic             targetInValid,
    input  logic             targetInLast,
    input  swPkg::scoreT     targetInScore,
    // result
    output swPkg::scoreT     score,
    output swPkg::tPosT      scoreJ,
    output logic             scoreValid,
    input  logic             scoreReady
);

    swPkg::scoreT match;
    swPkg::scoreT mismatch;
    swPkg::scoreT gap;
    logic         stepEn;
    logic         bottomStart;
    logic         bottomLast;
    swPkg::scoreT bottomH;
    logic         scoreAccepted;

    systolicArray i_systolicArray (
        .clk           (clk),
        .rst           (rst),
        .queryIn       (queryIn),
        .queryEn       (queryEn),
        .targetIn      (targetIn),
        .targetInStart (targetInStart),
        .targetInValid (targetInValid),
        .targetInLast  (targetInLast),
        .targetInScore (targetInScore),
        .match         (match),
        .mismatch      (mismatch),
        .gap           (gap),
        .queryReady    (queryReady),
        .stepEn        (stepEn),
        .bottomStart   (bottomStart),
        .bottomLast    (bottomLast),
        .bottomH       (bottomH)
    );

    scoreTracker i_scoreTracker (
        .clk           (clk),
        .rst           (rst),
        .stepEn        (stepEn),
        .bottomStart   (bottomStart),
        .bottomLast    (bottomLast),
        .bottomH       (bottomH),
        .scoreReady    (scoreReady),
        .score         (score),
        .scoreJ        (scoreJ),
        .scoreValid    (scoreValid),
        .scoreAccepted (scoreAccepted)
    );

    // target starts counted straight off the input strobe
    alignConfigApb i_alignConfigApb (
        .clk           (clk),
        .rst           (rst),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .targetStarted (targetInStart),
        .scoreAccepted (scoreAccepted),
        .prdata        (prdata),
        .pslverr       (pslverr),
        .match         (match),
        .mismatch      (mismatch),
        .gap           (gap)
    );

endmodule

// ==== systolicArray/swCell.sv ====
/*
 * systolic processing element, holds one query base and produces
 * one H entry of the DP table per step
 */
`timescale 1ns/1ps
`include "sw_defines.svh"

module swCell (
    input  logic         clk,
    input  logic         rst,
    input  logic         stepEn,
    input  logic         start,
    input  logic         last,
    input  swPkg::baseT  queryBase,
    input  logic         queryEn,
    input  swPkg::scoreT match,
    input  swPkg::scoreT mismatch,
    input  swPkg::scoreT gap,
    input  swPkg::baseT  targetBaseIn,
    input  swPkg::scoreT hIn,
    output swPkg::baseT  targetBaseOut,
    output swPkg::scoreT hOut
);

    // signed max of two scores
    function automatic swPkg::scoreT maxScore(input swPkg::scoreT a, input swPkg::scoreT b);
        maxScore = (a > b) ? a : b;
    endfunction

    // latched query base and its enable
    swPkg::baseT  qBase;
    logic         qEn;

    // H(i, j-1) from the row above, kept for the diagonal move
    swPkg::scoreT diag;

    swPkg::scoreT subScore;
    swPkg::scoreT diagCand;
    swPkg::scoreT upCand;
    swPkg::scoreT leftCand;
    swPkg::scoreT nextH;

    ////////////////////////////////////////////////////////////
    // table entry
    ////////////////////////////////////////////////////////////

    always_comb begin
        subScore = (qBase == targetBaseIn) ? match : mismatch;
        diagCand = diag + subScore;
        // gap in the target, coming down from the row above
        upCand   = hIn + gap;
        // gap in the query, our own last output
        leftCand = hOut + gap;
        nextH    = maxScore(diagCand, maxScore(upCand, leftCand));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            qEn <= 1'b0;
        end else if (stepEn && start) begin
            qEn <= queryEn;
        end
    end

    always_ff @(posedge clk) begin
        if (stepEn) begin
            targetBaseOut <= targetBaseIn;
            diag          <= hIn;
            if (start) begin
                qBase <= queryBase;
                // column 0 boundary H(i+1,0), a masked cell just passes hIn on
                hOut  <= queryEn ? hIn + gap : hIn;
            end else begin
                hOut  <= qEn ? nextH : hIn;
            end
        end
    end

    // start strobes only reach a cell on step cycles
    cellStartOnStep: assert property (@(posedge clk) disable iff (rst) start |-> stepEn);

    // a target never ends on the same step that starts it in this cell
    cellLastNotStart: assert property (@(posedge clk) disable iff (rst)
        (start && last) |-> 1'b0);

endmodule

// ==== systolicArray/systolicArray.sv ====
/*
 * sequencer plus chain of SW_MAX_QUERY_LEN cells, bottom row out
 */
`timescale 1ns/1ps
`include "sw_defines.svh"

module systolicArray (
    input  logic             clk,
    input  logic             rst,
    input  swPkg::queryT     queryIn,
    input  swPkg::queryMaskT queryEn,
    input  swPkg::baseT      targetIn,
    input  logic             targetInStart,
    input  logic             targetInValid,
    input  logic             targetInLast,
    input  swPkg::scoreT     targetInScore,
    input  swPkg::scoreT     match,
    input  swPkg::scoreT     mismatch,
    input  swPkg::scoreT     gap,
    output swPkg::queryMaskT queryReady,
    output logic             stepEn,
    output logic             bottomStart,
    output logic             bottomLast,
    output swPkg::scoreT     bottomH
);

    logic [`SW_MAX_QUERY_LEN+1:0] startBits;
    logic [`SW_MAX_QUERY_LEN+1:0] lastBits;

    // cell c reads entry c and drives entry c+1
    swPkg::baseT  baseChain [0:`SW_MAX_QUERY_LEN];
    swPkg::scoreT hChain    [0:`SW_MAX_QUERY_LEN];

    targetSequencer i_targetSequencer (
        .clk           (clk),
        .rst           (rst),
        .targetInStart (targetInStart),
        .targetInValid (targetInValid),
        .targetInLast  (targetInLast),
        .targetIn      (targetIn),
        .targetInScore (targetInScore),
        .gap           (gap),
        .stepEn        (stepEn),
        .startBits     (startBits),
        .lastBits      (lastBits),
        .targetBase    (baseChain[0]),
        .rowZeroScore  (hChain[0]),
        .queryReady    (queryReady)
    );

    for (genvar c = 0; c < `SW_MAX_QUERY_LEN; c++) begin : cellGen
        swCell i_swCell (
            .clk           (clk),
            .rst           (rst),
            .stepEn        (stepEn),
            .start         (startBits[c]),
            .last          (lastBits[c]),
            // query bus split, base 0 in the low bits
            .queryBase     (queryIn[c*`SW_BASE_W +: `SW_BASE_W]),
            .queryEn       (queryEn[c]),
            .match         (match),
            .mismatch      (mismatch),
            .gap           (gap),
            .targetBaseIn  (baseChain[c]),
            .hIn           (hChain[c]),
            .targetBaseOut (baseChain[c+1]),
            .hOut          (hChain[c+1])
        );
    end

    // bottom-row view for the tracker
    assign bottomH     = hChain[`SW_MAX_QUERY_LEN];
    assign bottomStart = startBits[`SW_MAX_QUERY_LEN];
    // one step later, once the last bottom H has been compared
    assign bottomLast  = lastBits[`SW_MAX_QUERY_LEN+1];

endmodule

// ==== systolicArray/targetSequencer.sv ====
/*
 * target framing, step enable, start/last strobe chains,
 * query-ready flags and the row-0 boundary score
 */
`timescale 1ns/1ps
`include "sw_defines.svh"

module targetSequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          targetInStart,
    input  logic                          targetInValid,
    input  logic                          targetInLast,
    input  swPkg::baseT                   targetIn,
    input  swPkg::scoreT                  targetInScore,
    input  swPkg::scoreT                  gap,
    output logic                          stepEn,
    output logic [`SW_MAX_QUERY_LEN+1:0]  startBits,
    output logic [`SW_MAX_QUERY_LEN+1:0]  lastBits,
    output swPkg::baseT                   targetBase,
    output swPkg::scoreT                  rowZeroScore,
    output swPkg::queryMaskT              queryReady
);

    localparam int ChainLen = `SW_MAX_QUERY_LEN + 2;

    // heads load every cycle, so a strobe is never lost on a stalled step
    logic                startHead;
    logic                lastHead;
    logic [ChainLen-1:1] startChain;
    logic [ChainLen-1:1] lastChain;
    logic [ChainLen-1:0] startRaw;
    logic [ChainLen-1:0] lastRaw;
    logic                midTarget;
    logic                allDone;

    assign startRaw = {startChain, startHead};
    assign lastRaw  = {lastChain, lastHead};

    // cells only see strobes on step cycles
    assign startBits = startRaw & {ChainLen{stepEn}};
    assign lastBits  = lastRaw & {ChainLen{stepEn}};

    assign queryReady = startBits[`SW_MAX_QUERY_LEN-1:0] | {`SW_MAX_QUERY_LEN{allDone}};

    always_ff @(posedge clk) begin
        targetBase <= targetIn;
    end

    ////////////////////////////////////////////////////////////
    // framing and step control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            startHead  <= 1'b0;
            lastHead   <= 1'b0;
            startChain <= '0;
            lastChain  <= '0;
            midTarget  <= 1'b0;
            stepEn     <= 1'b1;
            allDone    <= 1'b1;
        end else begin
            startHead <= targetInStart;
            // last counts only with a valid base
            lastHead  <= targetInValid & targetInLast;
            if (stepEn) begin
                startChain <= startRaw[ChainLen-2:0];
                lastChain  <= lastRaw[ChainLen-2:0];
            end
            if (targetInStart) begin
                midTarget <= 1'b1;
            end else if (targetInValid && targetInLast) begin
                midTarget <= 1'b0;
            end
            // inside a target advance one cycle after each valid base
            stepEn <= midTarget ? targetInValid : 1'b1;
            // a start still inside the cell range keeps the query busy
            if (startRaw[`SW_MAX_QUERY_LEN-1:0] != '0) begin
                allDone <= 1'b0;
            end else if (lastBits[`SW_MAX_QUERY_LEN-1]) begin
                allDone <= 1'b1;
            end
        end
    end

    // row 0 of the table, one gap per target position
    always_ff @(posedge clk) begin
        if (targetInStart) begin
            rowZeroScore <= targetInScore;
        end else if (stepEn) begin
            rowZeroScore <= rowZeroScore + gap;
        end
    end

    seqNoOverlap: assert property (@(posedge clk) disable iff (rst)
        targetInStart |-> !midTarget);

endmodule

// ==== tb/tbRefModel.svh ====
/*
 * reference alignment, xorshift random source, value check
 * and APB bus tasks for the aligner testbench
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// random source
////////////////////////////////////////////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] randWord();
    rngState = xorshift32(rngState);
    return rngState;
endfunction

function automatic int randBelow(input int n);
    return int'(randWord() % 32'(n));
endfunction

////////////////////////////////////////////////////////////
// reference DP table, linear gaps
////////////////////////////////////////////////////////////

// best of the last query row for j >= 1, earliest j on a tie
function automatic int refAlign(input swPkg::queryT query, input int qLen,
        input swPkg::baseT tgt [0:255], input int tLen, input int startScore,
        input int matchV, input int mismatchV, input int gapV, output int bestJ);
    int prevRow [0:255];
    int curRow [0:255];
    int diagC;
    int best;
    swPkg::baseT qBase;
    // row 0, one gap per target position
    for (int j = 0; j <= tLen; j++) begin
        prevRow[j] = startScore + j * gapV;
    end
    for (int i = 1; i <= qLen; i++) begin
        qBase = query[(i-1)*`SW_BASE_W +: `SW_BASE_W];
        // column 0, one gap per query position
        curRow[0] = startScore + i * gapV;
        for (int j = 1; j <= tLen; j++) begin
            diagC = prevRow[j-1] + ((qBase == tgt[j-1]) ? matchV : mismatchV);
            curRow[j] = diagC;
            if (prevRow[j] + gapV > curRow[j]) begin
                curRow[j] = prevRow[j] + gapV;
            end
            if (curRow[j-1] + gapV > curRow[j]) begin
                curRow[j] = curRow[j-1] + gapV;
            end
        end
        prevRow = curRow;
    end
    best  = prevRow[1];
    bestJ = 0;
    for (int j = 2; j <= tLen; j++) begin
        if (prevRow[j] > best) begin
            best  = prevRow[j];
            bestJ = j - 1;
        end
    end
    return best;
endfunction

// sign extend a register word from the score width
function automatic int asScore(input logic [31:0] word);
    swPkg::scoreT s;
    s = word[`SW_SCORE_W-1:0];
    return int'(s);
endfunction

task automatic checkValue(input string what, input int expected, input int actual);
    checkCount++;
    if (expected != actual) begin
        errorCount++;
        $display("Fail %s %s: expected %0d, actual %0d", testName, what, expected, actual);
    end
endtask

////////////////////////////////////////////////////////////
// APB master, setup cycle then access cycle
////////////////////////////////////////////////////////////

task automatic apbWrite(input regPkg::regAddrT addr, input logic [31:0] data,
        output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= 1'b1;
    pwdata  <= data;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    // edge closing the access cycle
    @(posedge clk);
    err = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic apbRead(input regPkg::regAddrT addr, output logic [31:0] data,
        output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    data = prdata;
    err  = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

`endif

// ==== tb/tbSwAligner.sv ====
/*
 * aligner testbench top, clock, reset, DUT, stimulus,
 * result comparison and summary
 */
`timescale 1ns/1ps
`include "sw_defines.svh"

module tbSwAligner;

    localparam int ValidLimit = 1000;
    localparam int DrainLimit = 4000;

    logic             clk;
    logic             rst;
    regPkg::regAddrT  paddr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    logic             pslverr;
    swPkg::queryT     queryIn;
    swPkg::queryMaskT queryEn;
    swPkg::queryMaskT queryReady;
    swPkg::baseT      targetIn;
    logic             targetInStart;
    logic             targetInValid;
    logic             targetInLast;
    swPkg::scoreT     targetInScore;
    swPkg::scoreT     score;
    swPkg::tPosT      scoreJ;
    logic             scoreValid;
    logic             scoreReady;

    // expected results in target order
    int expScores [$];
    int expJs [$];

    // scoring values programmed in the DUT
    int matchVal;
    int mismatchVal;
    int gapVal;

    swPkg::queryT curQuery;
    int           curQLen;
    logic [31:0]  rngState = 32'h3f2aaec9;
    string        testName;
    int           testCount;
    int           checkCount;
    int           errorCount;
    int           testErrStart;
    int           totalTargets;

    `include "tbRefModel.svh"

    swAligner i_swAligner (
        .clk           (clk),
        .rst           (rst),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pslverr       (pslverr),
        .queryIn       (queryIn),
        .queryEn       (queryEn),
        .queryReady    (queryReady),
        .targetIn      (targetIn),
        .targetInStart (targetInStart),
        .targetInValid (targetInValid),
        .targetInLast  (targetInLast),
        .targetInScore (targetInScore),
        .score         (score),
        .scoreJ        (scoreJ),
        .scoreValid    (scoreValid),
        .scoreReady    (scoreReady)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // test bookkeeping and waits
    ////////////////////////////////////////////////////////////

    task automatic abortOnTimeout(input string what);
        $display("timeout in %s while waiting for %s", testName, what);
        $display("sim failed");
        $finish;
    endtask

    task automatic beginTest(input string name);
        testName     = name;
        testErrStart = errorCount;
    endtask

    task automatic endTest();
        testCount++;
        if (errorCount == testErrStart) begin
            $display("%s: ok", testName);
        end else begin
            $display("%s: %0d errors", testName, errorCount - testErrStart);
        end
    endtask

    task automatic waitForScore();
        int cycles;
        cycles = 0;
        while (!scoreValid) begin
            @(posedge clk);
            cycles++;
            if (cycles > ValidLimit) begin
                abortOnTimeout("scoreValid");
            end
        end
    endtask

    // every queued result has been accepted
    task automatic waitForDrain();
        int cycles;
        cycles = 0;
        while (expScores.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > DrainLimit) begin
                abortOnTimeout("all pending results");
            end
        end
        checkValue("queryReady", 32'hffff, int'(queryReady));
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic readAndCheck(input regPkg::regAddrT addr, input string what,
            input int expected, input bit isScore);
        logic [31:0] rd;
        logic        err;
        apbRead(addr, rd, err);
        checkValue({what, " slave error"}, 0, int'(err));
        checkValue(what, expected, isScore ? asScore(rd) : int'(rd));
    endtask

    task automatic writeAndVerify(input regPkg::regAddrT addr, input string what,
            input int value);
        logic err;
        apbWrite(addr, 32'(value), err);
        checkValue({what, " write error"}, 0, int'(err));
        readAndCheck(addr, what, value, 1'b1);
    endtask

    task automatic setScoring(input int m, input int mm, input int g);
        writeAndVerify(regPkg::REG_MATCH, "match", m);
        writeAndVerify(regPkg::REG_MISMATCH, "mismatch", mm);
        writeAndVerify(regPkg::REG_GAP, "gap", g);
        matchVal    = m;
        mismatchVal = mm;
        gapVal      = g;
    endtask

    // upper bases stay random and only the enables mask them
    task automatic loadQuery(input int qLen);
        @(posedge clk);
        curQuery = randWord();
        curQLen  = qLen;
        queryIn <= curQuery;
        queryEn <= swPkg::queryMaskT'((1 << qLen) - 1);
    endtask

    // start strobe, bases with optional valid gaps, then one idle cycle
    task automatic sendTarget(input int tLen, input int startScore, input bit useGaps);
        swPkg::baseT tgt [0:255];
        int          expJ;
        int          expScore;
        int          gapLen;
        for (int j = 0; j < tLen; j++) begin
            tgt[j] = swPkg::baseT'(randBelow(4));
        end
        expScore = refAlign(curQuery, curQLen, tgt, tLen, startScore,
            matchVal, mismatchVal, gapVal, expJ);
        expScores.push_back(expScore);
        expJs.push_back(expJ);
        totalTargets++;
        @(posedge clk);
        targetInStart <= 1'b1;
        targetInScore <= swPkg::scoreT'(startScore);
        for (int j = 0; j < tLen; j++) begin
            @(posedge clk);
            targetInStart <= 1'b0;
            targetInValid <= 1'b1;
            targetIn      <= tgt[j];
            targetInLast  <= (j == tLen - 1);
            gapLen = (useGaps && j < tLen - 1) ? randBelow(3) : 0;
            for (int g = 0; g < gapLen; g++) begin
                @(posedge clk);
                // junk on the bus while not valid
                targetInValid <= 1'b0;
                targetIn      <= swPkg::baseT'(randBelow(4));
            end
        end
        @(posedge clk);
        targetInValid <= 1'b0;
        targetInLast  <= 1'b0;
    endtask

    // result compare on each accepted transfer
    always @(posedge clk) begin
        if (!rst && scoreValid && scoreReady) begin
            if (expScores.size() == 0) begin
                errorCount++;
                $display("%s: result %0d arrived with no target pending", testName, score);
            end else begin
                checkValue("score", expScores.pop_front(), int'(score));
                checkValue("scoreJ", expJs.pop_front(), int'(scoreJ));
            end
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        rst           <= 1'b1;
        paddr         <= '0;
        psel          <= 1'b0;
        penable       <= 1'b0;
        pwrite        <= 1'b0;
        pwdata        <= '0;
        queryIn       <= '0;
        queryEn       <= '1;
        targetIn      <= '0;
        targetInStart <= 1'b0;
        targetInValid <= 1'b0;
        targetInLast  <= 1'b0;
        targetInScore <= '0;
        scoreReady    <= 1'b1;
        testName      = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        beginTest("reset values");
        checkValue("scoreValid", 0, int'(scoreValid));
        checkValue("pslverr", 0, int'(pslverr));
        checkValue("queryReady", 32'hffff, int'(queryReady));
        readAndCheck(regPkg::REG_MATCH, "match", `SW_MATCH_RST, 1'b1);
        readAndCheck(regPkg::REG_MISMATCH, "mismatch", `SW_MISMATCH_RST, 1'b1);
        readAndCheck(regPkg::REG_GAP, "gap", `SW_GAP_RST, 1'b1);
        readAndCheck(regPkg::REG_TARGET_COUNT, "target count", 0, 1'b0);
        readAndCheck(regPkg::REG_SCORE_COUNT, "score count", 0, 1'b0);
        endTest();

        // mismatch stays above gap so column 0 never wins the bottom row
        beginTest("full query");
        setScoring(3, -2, -3);
        loadQuery(`SW_MAX_QUERY_LEN);
        sendTarget(5, 0, 1'b0);
        sendTarget(16, 0, 1'b0);
        sendTarget(23, 0, 1'b0);
        sendTarget(40, 0, 1'b0);
        waitForDrain();
        endTest();

        beginTest("short query with gaps");
        loadQuery(7);
        sendTarget(12, 25, 1'b1);
        sendTarget(30, -40, 1'b1);
        sendTarget(9, 7, 1'b1);
        waitForDrain();
        endTest();

        beginTest("back-pressure");
        @(posedge clk);
        scoreReady <= 1'b0;
        sendTarget(20, 3, 1'b1);
        waitForScore();
        // the held result is the only one pending, at the head of the queue
        repeat (10) begin
            @(posedge clk);
            checkValue("held scoreValid", 1, int'(scoreValid));
            checkValue("held score", expScores[0], int'(score));
            checkValue("held scoreJ", expJs[0], int'(scoreJ));
        end
        scoreReady <= 1'b1;
        waitForDrain();
        sendTarget(14, -6, 1'b0);
        waitForDrain();
        endTest();

        beginTest("counters and slave error");
        readAndCheck(regPkg::REG_TARGET_COUNT, "target count", totalTargets, 1'b0);
        readAndCheck(regPkg::REG_SCORE_COUNT, "score count", totalTargets, 1'b0);
        apbRead(8'h14, rd, err);
        checkValue("unmapped read error", 1, int'(err));
        apbWrite(regPkg::REG_SCORE_COUNT, 32'h0, err);
        checkValue("read-only write error", 1, int'(err));
        readAndCheck(regPkg::REG_SCORE_COUNT, "score count after write", totalTargets, 1'b0);
        endTest();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
